// File: Makefile
# Verilator build and run of the execute unit testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module exu_tb
	./obj_dir/Vexu_tb

clean:
	rm -rf obj_dir

// File: all.f
+incdir+logic
+incdir+sim
logic/exu_pkg.sv
logic/alu_stage.sv
logic/div_unit.sv
logic/retire_ctrl.sv
logic/exu_top.sv
sim/exu_tb.sv

// File: logic/alu_stage.sv
`timescale 1ns/1ps

module alu_stage import exu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      start_i,
    input  logic      hold_i,
    input  uop_e      uop_i,
    input  xlen_t     a_i,
    input  xlen_t     b_i,
    input  reg_addr_t rd_i,
    output logic      valid_o,
    output reg_addr_t rd_o,
    output xlen_t     result_o
);

    xlen_t      alu_res;
    logic [4:0] shamt;

    // only the low five bits of b select the shift
    assign shamt = b_i[4:0];

    always_comb begin
        alu_res = '0;
        case (uop_i)
            UOP_ADD:  alu_res = a_i + b_i;
            UOP_SUB:  alu_res = a_i - b_i;
            UOP_AND:  alu_res = a_i & b_i;
            UOP_OR:   alu_res = a_i | b_i;
            UOP_XOR:  alu_res = a_i ^ b_i;
            UOP_SLL:  alu_res = a_i << shamt;
            UOP_SRL:  alu_res = a_i >> shamt;
            UOP_SRA:  alu_res = xlen_t'($signed(a_i) >>> shamt);
            UOP_SLT:  alu_res[0] = $signed(a_i) < $signed(b_i);
            UOP_SLTU: alu_res[0] = a_i < b_i;
            // divide ops never start here
            default:  alu_res = '0;
        endcase
    end

    // valid drops once the result moves on to write-back
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (start_i) begin
            valid_o <= 1'b1;
        end else if (!hold_i) begin
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            result_o <= alu_res;
            rd_o     <= rd_i;
        end
    end

    // a held result must never be overwritten by a new issue
    start_not_on_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> !(valid_o && hold_i));

endmodule

// File: logic/div_unit.sv
`timescale 1ns/1ps

`include "exu_settings.svh"

module div_unit import exu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      start_i,
    input  uop_e      uop_i,
    input  xlen_t     a_i,
    input  xlen_t     b_i,
    input  reg_addr_t rd_i,
    output logic      done_o,
    output reg_addr_t rd_o,
    output xlen_t     result_o
);

    div_state_e               state_q;
    logic [$clog2(`XLEN)-1:0] cnt_q;
    xlen_t                    quo_q;
    xlen_t                    rem_q;
    xlen_t                    divisor_q;
    reg_addr_t                rd_q;
    logic                     rem_sel_q;
    logic                     neg_quo_q;
    logic                     neg_rem_q;

    logic          op_signed;
    logic          op_rem;
    logic          div_zero;
    logic          overflow;
    xlen_t         a_abs;
    xlen_t         b_abs;
    logic [`XLEN:0] rem_shift;
    logic [`XLEN:0] trial;
    xlen_t         quo_fix;
    xlen_t         rem_fix;

    always_comb begin
        op_signed = (uop_i == UOP_DIV) || (uop_i == UOP_REM);
        op_rem    = (uop_i == UOP_REM) || (uop_i == UOP_REMU);
        div_zero  = (b_i == '0);
        // most negative value over minus one
        overflow  = op_signed && a_i[`XLEN-1] && (a_i[`XLEN-2:0] == '0) && (&b_i);
        a_abs     = (op_signed && a_i[`XLEN-1]) ? xlen_t'(-a_i) : a_i;
        b_abs     = (op_signed && b_i[`XLEN-1]) ? xlen_t'(-b_i) : b_i;
    end

    // one restoring step: shift in next dividend bit, try the subtract
    assign rem_shift = {rem_q, quo_q[`XLEN-1]};
    assign trial     = rem_shift - {1'b0, divisor_q};

    assign quo_fix = neg_quo_q ? xlen_t'(-quo_q) : quo_q;
    assign rem_fix = neg_rem_q ? xlen_t'(-rem_q) : rem_q;

    assign rd_o = rd_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        cnt_q <= '0;
                        // corner cases have their answer already
                        if (div_zero || overflow) begin
                            state_q <= DIV_FINISH;
                        end else begin
                            state_q <= DIV_RUN;
                        end
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (&cnt_q) begin
                        state_q <= DIV_FINISH;
                    end
                end
                DIV_FINISH: begin
                    done_o  <= 1'b1;
                    state_q <= DIV_IDLE;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            DIV_IDLE: begin
                if (start_i) begin
                    rd_q      <= rd_i;
                    rem_sel_q <= op_rem;
                    divisor_q <= b_abs;
                    if (div_zero) begin
                        quo_q     <= '1;
                        rem_q     <= a_i;
                        neg_quo_q <= 1'b0;
                        neg_rem_q <= 1'b0;
                    end else if (overflow) begin
                        quo_q     <= a_i;
                        rem_q     <= '0;
                        neg_quo_q <= 1'b0;
                        neg_rem_q <= 1'b0;
                    end else begin
                        quo_q     <= a_abs;
                        rem_q     <= '0;
                        neg_quo_q <= op_signed && (a_i[`XLEN-1] ^ b_i[`XLEN-1]);
                        neg_rem_q <= op_signed && a_i[`XLEN-1];
                    end
                end
            end
            DIV_RUN: begin
                // trial sign bit clear means the subtract fits
                if (!trial[`XLEN]) begin
                    rem_q <= trial[`XLEN-1:0];
                    quo_q <= {quo_q[`XLEN-2:0], 1'b1};
                end else begin
                    rem_q <= rem_shift[`XLEN-1:0];
                    quo_q <= {quo_q[`XLEN-2:0], 1'b0};
                end
            end
            DIV_FINISH: result_o <= rem_sel_q ? rem_fix : quo_fix;
            default: ;
        endcase
    end

    start_only_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> state_q == DIV_IDLE);

endmodule

// File: logic/exu_pkg.sv
`include "exu_settings.svh"

package exu_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // ALU ops first, divide ops in the upper codes
    typedef enum logic [3:0] {
        UOP_ADD  = 4'd0,
        UOP_SUB  = 4'd1,
        UOP_AND  = 4'd2,
        UOP_OR   = 4'd3,
        UOP_XOR  = 4'd4,
        UOP_SLL  = 4'd5,
        UOP_SRL  = 4'd6,
        UOP_SRA  = 4'd7,
        UOP_SLT  = 4'd8,
        UOP_SLTU = 4'd9,
        UOP_DIV  = 4'd10,
        UOP_DIVU = 4'd11,
        UOP_REM  = 4'd12,
        UOP_REMU = 4'd13
    } uop_e;

    // divide tracking in the retire controller
    typedef enum logic [1:0] {
        RET_IDLE,
        RET_DIV_WAIT,
        RET_DIV_DONE
    } retire_state_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FINISH
    } div_state_e;

endpackage

// File: logic/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// data path width of the execute unit
`define XLEN 32

// destination register number width
`define REG_ADDR_W 5

`endif

// File: logic/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // issue side
    input  logic      issue_valid_i,
    output logic      issue_ready_o,
    input  uop_e      issue_uop_i,
    input  xlen_t     issue_a_i,
    input  xlen_t     issue_b_i,
    input  reg_addr_t issue_rd_i,
    // write-back side
    output logic      wb_valid_o,
    input  logic      wb_ready_i,
    output reg_addr_t wb_rd_o,
    output xlen_t     wb_data_o
);

    logic      alu_start;
    logic      alu_hold;
    logic      alu_valid;
    reg_addr_t alu_rd;
    xlen_t     alu_result;

    logic      div_start;
    logic      div_done;
    reg_addr_t div_rd;
    xlen_t     div_result;

    // operands go straight to both units, retire_ctrl picks one
    alu_stage u_alu (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (alu_start),
        .hold_i   (alu_hold),
        .uop_i    (issue_uop_i),
        .a_i      (issue_a_i),
        .b_i      (issue_b_i),
        .rd_i     (issue_rd_i),
        .valid_o  (alu_valid),
        .rd_o     (alu_rd),
        .result_o (alu_result)
    );

    div_unit u_div (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (div_start),
        .uop_i    (issue_uop_i),
        .a_i      (issue_a_i),
        .b_i      (issue_b_i),
        .rd_i     (issue_rd_i),
        .done_o   (div_done),
        .rd_o     (div_rd),
        .result_o (div_result)
    );

    retire_ctrl u_retire (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_uop_i   (issue_uop_i),
        .wb_ready_i    (wb_ready_i),
        .alu_valid_i   (alu_valid),
        .alu_rd_i      (alu_rd),
        .alu_result_i  (alu_result),
        .div_done_i    (div_done),
        .div_rd_i      (div_rd),
        .div_result_i  (div_result),
        .issue_ready_o (issue_ready_o),
        .alu_start_o   (alu_start),
        .alu_hold_o    (alu_hold),
        .div_start_o   (div_start),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

// File: logic/retire_ctrl.sv
`timescale 1ns/1ps

module retire_ctrl import exu_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          issue_valid_i,
    input  uop_e          issue_uop_i,
    input  logic          wb_ready_i,
    input  logic          alu_valid_i,
    input  reg_addr_t     alu_rd_i,
    input  xlen_t         alu_result_i,
    input  logic          div_done_i,
    input  reg_addr_t     div_rd_i,
    input  xlen_t         div_result_i,
    output logic          issue_ready_o,
    output logic          alu_start_o,
    output logic          alu_hold_o,
    output logic          div_start_o,
    output logic          wb_valid_o,
    output reg_addr_t     wb_rd_o,
    output xlen_t         wb_data_o
);

    retire_state_e state_q;
    retire_state_e state_d;

    logic is_div;
    logic wb_free;
    logic div_pending;
    logic alu_load;
    logic div_load;

    assign is_div = (issue_uop_i == UOP_DIV) || (issue_uop_i == UOP_DIVU)
                 || (issue_uop_i == UOP_REM) || (issue_uop_i == UOP_REMU);

    // write-back register is empty or drains this cycle
    assign wb_free    = !wb_valid_o || wb_ready_i;
    assign alu_hold_o = !wb_free;

    // no issue during a divide, or when the ALU result cannot move on
    assign issue_ready_o = (state_q == RET_IDLE) && !(alu_valid_i && !wb_free);
    assign alu_start_o   = issue_valid_i && issue_ready_o && !is_div;
    assign div_start_o   = issue_valid_i && issue_ready_o && is_div;

    // div result waits until older ALU results have left
    assign div_pending = (state_q == RET_DIV_DONE) || (state_q == RET_DIV_WAIT && div_done_i);
    assign alu_load    = alu_valid_i && wb_free;
    assign div_load    = div_pending && !alu_valid_i && wb_free;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RET_IDLE: begin
                if (div_start_o) begin
                    state_d = RET_DIV_WAIT;
                end
            end
            RET_DIV_WAIT: begin
                if (div_load) begin
                    state_d = RET_IDLE;
                end else if (div_done_i) begin
                    state_d = RET_DIV_DONE;
                end
            end
            RET_DIV_DONE: begin
                if (div_load) begin
                    state_d = RET_IDLE;
                end
            end
            default: state_d = RET_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= RET_IDLE;
            wb_valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            if (alu_load || div_load) begin
                wb_valid_o <= 1'b1;
            end else if (wb_ready_i) begin
                wb_valid_o <= 1'b0;
            end
        end
    end

    // write-back payload
    always_ff @(posedge clk_i) begin
        if (alu_load) begin
            wb_rd_o   <= alu_rd_i;
            wb_data_o <= alu_result_i;
        end else if (div_load) begin
            wb_rd_o   <= div_rd_i;
            wb_data_o <= div_result_i;
        end
    end

    wb_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_valid_o && !wb_ready_i) |=>
            (wb_valid_o && $stable(wb_data_o) && $stable(wb_rd_o)));

    // a divide result only shows up while one is outstanding
    div_done_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        div_done_i |-> state_q == RET_DIV_WAIT);

endmodule

// File: sim/exu_vectors.svh
// columns are uop, a, b, rd, expected result, drain before issue, timed with wb_ready high
// drain rows wait until every earlier result has retired
typedef struct packed {
    uop_e      uop;
    xlen_t     a;
    xlen_t     b;
    reg_addr_t rd;
    xlen_t     exp;
    logic      drain;
    logic      timed;
} vec_t;

localparam int NUM_VEC = 36;

vec_t vec_table [NUM_VEC] = '{
    // isolated ALU op, then back-to-back ALU ops
    '{UOP_ADD,  32'h0000_0005, 32'h0000_0007, 5'd1,  32'h0000_000C, 1'b1, 1'b1},
    '{UOP_SUB,  32'h0000_0010, 32'h0000_0020, 5'd2,  32'hFFFF_FFF0, 1'b1, 1'b1},
    '{UOP_AND,  32'hF0F0_1234, 32'h0FF0_FF00, 5'd3,  32'h00F0_1200, 1'b0, 1'b1},
    '{UOP_OR,   32'hF000_000F, 32'h0F00_00F0, 5'd4,  32'hFF00_00FF, 1'b0, 1'b1},
    '{UOP_XOR,  32'hAAAA_5555, 32'hFFFF_0000, 5'd5,  32'h5555_5555, 1'b0, 1'b1},
    '{UOP_SLL,  32'h0000_0001, 32'h0000_0024, 5'd6,  32'h0000_0010, 1'b0, 1'b1},
    // random back-pressure from here on
    '{UOP_SRL,  32'h8000_0000, 32'h0000_003F, 5'd7,  32'h0000_0001, 1'b1, 1'b0},
    '{UOP_SRA,  32'h8000_0000, 32'h0000_0004, 5'd8,  32'hF800_0000, 1'b0, 1'b0},
    '{UOP_SRA,  32'h7000_0000, 32'h0000_0021, 5'd9,  32'h3800_0000, 1'b0, 1'b0},
    '{UOP_SLT,  32'hFFFF_FFFF, 32'h0000_0001, 5'd10, 32'h0000_0001, 1'b0, 1'b0},
    '{UOP_SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 5'd11, 32'h0000_0000, 1'b0, 1'b0},
    '{UOP_SLT,  32'h0000_0001, 32'h8000_0000, 5'd12, 32'h0000_0000, 1'b0, 1'b0},
    '{UOP_SLTU, 32'h0000_0001, 32'h8000_0000, 5'd13, 32'h0000_0001, 1'b0, 1'b0},
    // mixed-sign divides, ALU ops right behind them
    '{UOP_DIV,  32'hFFFF_FFF9, 32'h0000_0002, 5'd14, 32'hFFFF_FFFD, 1'b0, 1'b0},
    '{UOP_REM,  32'hFFFF_FFF9, 32'h0000_0002, 5'd15, 32'hFFFF_FFFF, 1'b0, 1'b0},
    '{UOP_ADD,  32'h7FFF_FFFF, 32'h0000_0001, 5'd16, 32'h8000_0000, 1'b0, 1'b0},
    '{UOP_DIV,  32'h0000_0007, 32'hFFFF_FFFE, 5'd17, 32'hFFFF_FFFD, 1'b0, 1'b0},
    '{UOP_REM,  32'h0000_0007, 32'hFFFF_FFFE, 5'd18, 32'h0000_0001, 1'b0, 1'b0},
    '{UOP_DIVU, 32'hFFFF_FFF9, 32'h0000_0002, 5'd19, 32'h7FFF_FFFC, 1'b0, 1'b0},
    '{UOP_REMU, 32'hFFFF_FFF9, 32'h0000_0002, 5'd20, 32'h0000_0001, 1'b0, 1'b0},
    '{UOP_XOR,  32'h1234_5678, 32'hFFFF_FFFF, 5'd21, 32'hEDCB_A987, 1'b0, 1'b0},
    // divide by zero
    '{UOP_DIV,  32'h0000_0064, 32'h0000_0000, 5'd22, 32'hFFFF_FFFF, 1'b0, 1'b0},
    '{UOP_REM,  32'hFFFF_FF9C, 32'h0000_0000, 5'd23, 32'hFFFF_FF9C, 1'b0, 1'b0},
    '{UOP_DIVU, 32'h0000_0005, 32'h0000_0000, 5'd24, 32'hFFFF_FFFF, 1'b0, 1'b0},
    '{UOP_REMU, 32'h8000_0001, 32'h0000_0000, 5'd25, 32'h8000_0001, 1'b0, 1'b0},
    // signed overflow
    '{UOP_DIV,  32'h8000_0000, 32'hFFFF_FFFF, 5'd26, 32'h8000_0000, 1'b0, 1'b0},
    '{UOP_REM,  32'h8000_0000, 32'hFFFF_FFFF, 5'd27, 32'h0000_0000, 1'b0, 1'b0},
    '{UOP_SUB,  32'h0000_0000, 32'h0000_0001, 5'd28, 32'hFFFF_FFFF, 1'b0, 1'b0},
    '{UOP_DIV,  32'hFFFF_FF9C, 32'hFFFF_FFF9, 5'd29, 32'h0000_000E, 1'b0, 1'b0},
    '{UOP_REM,  32'hFFFF_FF9C, 32'hFFFF_FFF9, 5'd30, 32'hFFFF_FFFE, 1'b0, 1'b0},
    '{UOP_DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 5'd31, 32'h0000_0000, 1'b0, 1'b0},
    '{UOP_SLL,  32'hDEAD_BEEF, 32'h0000_0008, 5'd1,  32'hADBE_EF00, 1'b0, 1'b0},
    '{UOP_SRL,  32'hDEAD_BEEF, 32'h0000_0108, 5'd2,  32'h00DE_ADBE, 1'b0, 1'b0},
    '{UOP_ADD,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd3,  32'hFFFF_FFFE, 1'b0, 1'b0},
    '{UOP_DIVU, 32'h0000_0064, 32'h0000_0007, 5'd4,  32'h0000_000E, 1'b0, 1'b0},
    '{UOP_REMU, 32'h0000_0064, 32'h0000_0007, 5'd5,  32'h0000_0002, 1'b0, 1'b0}
};

// File: sim/exu_tb.sv
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

    `include "exu_vectors.svh"

    localparam int CYCLE_LIMIT = NUM_VEC * 40 + 100;

    logic      clk_i;
    logic      rst_n_i;
    logic      issue_valid_i;
    logic      issue_ready_o;
    uop_e      issue_uop_i;
    xlen_t     issue_a_i;
    xlen_t     issue_b_i;
    reg_addr_t issue_rd_i;
    logic      wb_valid_o;
    logic      wb_ready_i;
    reg_addr_t wb_rd_o;
    xlen_t     wb_data_o;

    int   cycle_cnt = 0;
    int   issued_cnt = 0;
    int   retired_cnt = 0;
    int   accept_cnt [NUM_VEC];
    logic bp_phase = 1'b0;

    exu_top dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_uop_i   (issue_uop_i),
        .issue_a_i     (issue_a_i),
        .issue_b_i     (issue_b_i),
        .issue_rd_i    (issue_rd_i),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        string msg;
        if (got !== exp) begin
            msg = $sformatf("Error: %s is %h, expected %h", name, got, exp);
            abort_run(msg);
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic issue_row(input int idx);
        issue_valid_i = 1'b1;
        issue_uop_i   = vec_table[idx].uop;
        issue_a_i     = vec_table[idx].a;
        issue_b_i     = vec_table[idx].b;
        issue_rd_i    = vec_table[idx].rd;
        @(negedge clk_i);
        while (!issue_ready_o) begin
            @(negedge clk_i);
        end
        accept_cnt[idx] = cycle_cnt;
        @(posedge clk_i);
        #1;
        issue_valid_i = 1'b0;
        issued_cnt++;
    endtask

    task automatic wait_idle();
        @(negedge clk_i);
        while (retired_cnt < issued_cnt) begin
            @(negedge clk_i);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run("run exceeded its cycle limit before all results retired");
        end
    end

    // about one cycle in four stalls the write-back side
    initial begin
        int unsigned seed;
        seed = $urandom(32'h386b921f);
        wb_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #1;
            if (bp_phase) begin
                wb_ready_i = ($urandom % 4) != 0;
            end else begin
                wb_ready_i = 1'b1;
            end
        end
    end

    // results must come back in issue order
    always @(negedge clk_i) begin
        if (rst_n_i && wb_valid_o && wb_ready_i) begin
            if (retired_cnt >= issued_cnt) begin
                abort_run("write-back result arrived with no operation outstanding");
            end else begin
                check_value("wb_rd_o", 32'(wb_rd_o), 32'(vec_table[retired_cnt].rd));
                check_value("wb_data_o", wb_data_o, vec_table[retired_cnt].exp);
                if (vec_table[retired_cnt].timed) begin
                    check_value("wb latency", cycle_cnt - accept_cnt[retired_cnt], 2);
                end
                retired_cnt++;
            end
        end
    end

    initial begin
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_uop_i   = UOP_ADD;
        issue_a_i     = '0;
        issue_b_i     = '0;
        issue_rd_i    = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("wb_valid_o", 32'(wb_valid_o), 0);
        check_value("issue_ready_o", 32'(issue_ready_o), 1);
        @(posedge clk_i);
        #1;
        for (int i = 0; i < NUM_VEC; i++) begin
            if (vec_table[i].drain) begin
                wait_idle();
                bp_phase = !vec_table[i].timed;
                @(posedge clk_i);
                #1;
            end
            issue_row(i);
            if (vec_table[i].timed && !vec_table[i].drain) begin
                check_value("issue gap", accept_cnt[i] - accept_cnt[i-1], 1);
            end
        end
        wait_idle();
        // a few more cycles to catch a duplicated result
        repeat (5) @(posedge clk_i);
        $display("TEST PASS");
        $finish;
    end

endmodule
